/* Bender.yml */
package:
  name: fp_cmp_accel

sources:
  - fpCmpPkg.sv
  - wbPkg.sv
  - cmpOperandRegs.sv
  - fpCmpLane.sv
  - cmpResultCollect.sv
  - fpCmpTop.sv
  - target: test
    files:
      - fpCmpTb_chk.sv
      - fpCmpTb.sv

/* all.f */
fpCmpPkg.sv
wbPkg.sv
cmpOperandRegs.sv
fpCmpLane.sv
cmpResultCollect.sv
fpCmpTop.sv
fpCmpTb_chk.sv
fpCmpTb.sv

/* cmpOperandRegs.sv */
// single wishbone slave, registered ack one edge after cyc&stb
// master must drop stb for a cycle after ack, no back-to-back
// start bit of CTRL is a one-cycle pulse and reads back as zero

module cmpOperandRegs
  import fpCmpPkg::*;
  import wbPkg::*;
#(
  parameter int NUM_LANES = 4
) (
  input  logic     clk,
  input  logic     arstN,
  input  wbReqT    wbReq,
  output wbRspT    wbRsp,
  output lanePairT pairs [NUM_LANES],
  output cmpCtrlT  ctrl,
  output logic     start,
  input  laneResT  results [NUM_LANES],
  input  logic [31:0] status
);

  logic        ackQ;
  logic [31:0] rdDatQ;  // read data, sampled with ack
  logic [31:0] rdMux;
  logic        busHit;  // new request this edge
  logic        wrHit;

  // guard on ackQ keeps ack to one cycle even if stb lingers
  assign busHit = wbReq.cyc & wbReq.stb & ~ackQ;
  assign wrHit  = busHit & wbReq.we;

  //////////////////////////////////////////////////////////////////////
  // handshake and start
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      ackQ  <= 1'b0;
      start <= 1'b0;
      ctrl  <= '0;
    end else begin
      ackQ  <= busHit;
      // start leaves on the same edge that acks the CTRL write
      start <= wrHit && (wbReq.adr == CTRL_ADR) && wbReq.dat[CTRL_START_BIT];
      if (wrHit && (wbReq.adr == CTRL_ADR)) begin
        ctrl.op  <= cmpOpT'(wbReq.dat[2:0]);  // raw bits kept, unused codes decode as no-op
        ctrl.zfa <= wbReq.dat[CTRL_ZFA_BIT];
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // operand registers
  //////////////////////////////////////////////////////////////////////

  // payload only, ack edge is the write edge
  always_ff @(posedge clk) begin
    for (int i = 0; i < NUM_LANES; i++) begin
      if (wrHit && (wbReq.adr == 6'(2 * i)))
        pairs[i].x.raw <= wbReq.dat;
      if (wrHit && (wbReq.adr == 6'(2 * i + 1)))
        pairs[i].y.raw <= wbReq.dat;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // read path
  //////////////////////////////////////////////////////////////////////

  // anything not matched reads zero
  always_comb begin
    rdMux = '0;
    for (int i = 0; i < NUM_LANES; i++) begin
      if (wbReq.adr == 6'(2 * i))
        rdMux = pairs[i].x.raw;
      if (wbReq.adr == 6'(2 * i + 1))
        rdMux = pairs[i].y.raw;
      if (wbReq.adr == FPRES_BASE + 6'(i))
        rdMux = results[i].fpRes.raw;
      if (wbReq.adr == INTRES_BASE + 6'(i))
        rdMux = {31'b0, results[i].intRes};  // zero-extended
    end
    if (wbReq.adr == CTRL_ADR) begin
      rdMux[2:0]          = ctrl.op;
      rdMux[CTRL_ZFA_BIT] = ctrl.zfa;       // start bit stays 0
    end
    if (wbReq.adr == STAT_ADR)
      rdMux = status;
  end

  // sampled on the ack edge, writes see no meaningful data
  always_ff @(posedge clk) begin
    if (busHit)
      rdDatQ <= wbReq.we ? 32'b0 : rdMux;
  end

  assign wbRsp.ack = ackQ;
  assign wbRsp.dat = rdDatQ;

endmodule

/* cmpResultCollect.sv */
// captures lane results the edge after lane valid
// done and sticky nv clear when start is seen, set again on capture

module cmpResultCollect
  import fpCmpPkg::*;
  import wbPkg::*;
#(
  parameter int NUM_LANES = 4
) (
  input  logic        clk,
  input  logic        arstN,
  input  laneResT     laneRes   [NUM_LANES],
  input  logic        laneValid [NUM_LANES],
  input  logic        start,
  output laneResT     results   [NUM_LANES],
  output logic [31:0] status
);

  logic                 done;
  logic [NUM_LANES-1:0] stickyNv;  // one per lane

  // lanes share start, so every valid bit rises together
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      done     <= 1'b0;
      stickyNv <= '0;
      for (int i = 0; i < NUM_LANES; i++)
        results[i] <= '0;  // results read as zero after reset
    end else begin
      if (start)
        done <= 1'b0;
      else if (laneValid[0])
        done <= 1'b1;
      for (int i = 0; i < NUM_LANES; i++) begin
        if (laneValid[i]) begin
          results[i]  <= laneRes[i];
          stickyNv[i] <= (stickyNv[i] & ~start) | laneRes[i].nv;
        end else if (start) begin
          stickyNv[i] <= 1'b0;
        end
      end
    end
  end

  // STAT layout from the register map
  always_comb begin
    status = '0;
    status[STAT_DONE_BIT] = done;
    status[STAT_NV_LSB +: NUM_LANES] = stickyNv;
  end

endmodule

/* fpCmpLane.sv */
// one binary32 compare lane, Zfa variants always present
// result and valid register one edge after start
// IEEE_NAN=1 returns x's payload quieted instead of the canonical NaN

module fpCmpLane
  import fpCmpPkg::*;
#(
  parameter bit IEEE_NAN = 1'b0
) (
  input  logic     clk,
  input  logic     arstN,
  input  lanePairT pair,
  input  cmpCtrlT  ctrl,
  input  logic     start,
  output laneResT  res,
  output logic     valid
);

  fpClassT xc, yc;
  fpWordU  x, y;
  fpWordU  nanRes;     // NaN returned by min/max
  fpWordU  fpResD;
  logic    ltAbs;      // |x| < |y|
  logic    lt, eq;
  logic    bothZero;
  logic    eitherNaN, eitherSNaN;
  logic    intResD, nvD;

  // unpacker work, per operand
  function automatic fpClassT classify(input fpWordU w);
    fpClassT c;
    logic    expOnes, expZero, manZero;
    expOnes  = &w.fields.exponent;
    expZero  = ~|w.fields.exponent;
    manZero  = ~|w.fields.mantissa;
    c.isZero = expZero & manZero;
    c.isInf  = expOnes & manZero;
    c.isNaN  = expOnes & ~manZero;
    c.isSNaN = c.isNaN & ~w.fields.mantissa[22];  // quiet bit clear
    c.hidden = ~expZero;
    return c;
  endfunction

  assign x  = pair.x;
  assign y  = pair.y;
  assign xc = classify(x);
  assign yc = classify(y);

  //////////////////////////////////////////////////////////////////////
  // ordering
  //////////////////////////////////////////////////////////////////////

  // unsigned compare on magnitude bits, sign handled below
  assign ltAbs = {xc.hidden, x.fields.exponent, x.fields.mantissa} <
                 {yc.hidden, y.fields.exponent, y.fields.mantissa};
  assign eq    = (x.raw == y.raw);  // bit-exact, so -0 != +0 here
  assign lt    = (x.fields.sign & ~y.fields.sign) |
                 (x.fields.sign & y.fields.sign & ~ltAbs & ~eq) |  // both negative, flip
                 (~x.fields.sign & ~y.fields.sign & ltAbs);

  assign bothZero   = xc.isZero & yc.isZero;
  assign eitherNaN  = xc.isNaN | yc.isNaN;
  assign eitherSNaN = xc.isSNaN | yc.isSNaN;

  //////////////////////////////////////////////////////////////////////
  // invalid flag
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    casez (ctrl.op)
      CMP_MIN, CMP_MAX, CMP_EQ: nvD = eitherSNaN;
      3'b0?1:  nvD = ctrl.zfa ? eitherSNaN : eitherNaN;  // fltq/fleq quiet, flt/fle signaling
      default: nvD = 1'b0;
    endcase
  end

  //////////////////////////////////////////////////////////////////////
  // min / max
  //////////////////////////////////////////////////////////////////////

  // payload from x even when only y is a NaN (minm/maxm)
  assign nanRes.raw = IEEE_NAN ? {x.fields.sign, 8'hFF, 1'b1, x.fields.mantissa[21:0]}
                               : CANON_NAN;

  always_comb begin
    if (ctrl.zfa && eitherNaN)
      fpResD = nanRes;                // minm/maxm propagate any NaN
    else if (xc.isNaN && yc.isNaN)
      fpResD = nanRes;
    else if (xc.isNaN)
      fpResD = y;                     // one NaN, other operand wins
    else if (yc.isNaN)
      fpResD = x;
    else if (ctrl.op[0])              // max
      fpResD = lt ? y : x;
    else                              // min
      fpResD = lt ? x : y;
  end

  // relational: zeros equal, any NaN unordered gives 0
  assign intResD = (((eq | bothZero) & ctrl.op[1]) |
                    (lt & ctrl.op[0] & ~bothZero)) & ~eitherNaN;

  //////////////////////////////////////////////////////////////////////
  // output stage
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN)
      valid <= 1'b0;
    else
      valid <= start;
  end

  // held until the next start, later operand writes don't disturb it
  always_ff @(posedge clk) begin
    if (start) begin
      res.fpRes  <= fpResD;
      res.intRes <= intResD;
      res.nv     <= nvD;
    end
  end

endmodule

/* fpCmpPkg.sv */
// binary32 only, no NaN boxing and no Fmt selection
// opcode encodings follow the scalar FPU compare unit
// fpClassT is built inside each lane, exported here for the checker

package fpCmpPkg;

  //////////////////////////////////////////////////////////////////////
  // word views
  //////////////////////////////////////////////////////////////////////

  typedef struct packed {
    logic        sign;
    logic [7:0]  exponent;  // biased
    logic [22:0] mantissa;  // fraction only, hidden bit implied
  } fpFieldsT;

  // one word, two decodings
  typedef union packed {
    logic [31:0] raw;     // exact equality, pass-through
    fpFieldsT    fields;  // classification, magnitude order
  } fpWordU;

  // operand class, one per operand
  typedef struct packed {
    logic isZero;
    logic isInf;
    logic isNaN;
    logic isSNaN;  // NaN with quiet bit clear
    logic hidden;  // implicit leading one, 0 for zero/subnormal
  } fpClassT;

  // riscv canonical quiet NaN
  parameter logic [31:0] CANON_NAN = 32'h7FC0_0000;

  //////////////////////////////////////////////////////////////////////
  // operation and lane data
  //////////////////////////////////////////////////////////////////////

  typedef enum logic [2:0] {
    CMP_LT  = 3'b001,  // flt / fltq
    CMP_EQ  = 3'b010,
    CMP_LE  = 3'b011,  // fle / fleq
    CMP_MAX = 3'b101,  // fmax / fmaxm
    CMP_MIN = 3'b110   // fmin / fminm
  } cmpOpT;

  typedef struct packed {
    cmpOpT op;
    logic  zfa;  // minm/maxm, quiet lt/le
  } cmpCtrlT;

  typedef struct packed {
    fpWordU x;
    fpWordU y;
  } lanePairT;

  typedef struct packed {
    fpWordU fpRes;   // min/max result
    logic   intRes;  // relational result, zero-extended on read
    logic   nv;      // invalid flag
  } laneResT;

endpackage

/* fpCmpTb.sv */
// table-driven testbench, default parameters (4 lanes, canonical NaN)
// batches share op and zfa, so table groups of NUM_LANES must agree on both
// random pairs are normal numbers only, no NaN or zero

module fpCmpTb
  import fpCmpPkg::*;
  import wbPkg::*;
();

  localparam int NUM_LANES   = 4;
  localparam int NUM_BATCHES = 11;  // 7 fixed, 4 random
  localparam int MAX_CYCLES  = 40 * (NUM_BATCHES + 1) + 16;  // one extra for readback
  localparam logic [31:0] SEED = 32'h0c1e497c;

  // operand constants
  localparam logic [31:0] PZERO = 32'h0000_0000;
  localparam logic [31:0] NZERO = 32'h8000_0000;
  localparam logic [31:0] PINF  = 32'h7F80_0000;
  localparam logic [31:0] NINF  = 32'hFF80_0000;
  localparam logic [31:0] QNAN  = 32'h7FC0_0000;  // also the canonical NaN
  localparam logic [31:0] QNANP = 32'h7FC1_2345;  // quiet, with payload
  localparam logic [31:0] SNAN  = 32'h7F80_0001;
  localparam logic [31:0] ONE   = 32'h3F80_0000;
  localparam logic [31:0] TWO   = 32'h4000_0000;
  localparam logic [31:0] MONE  = 32'hBF80_0000;
  localparam logic [31:0] MTWO  = 32'hC000_0000;

  typedef struct packed {
    logic [31:0] x;
    logic [31:0] y;
    logic [2:0]  op;
    logic        zfa;
    logic [31:0] fpRes;   // checked for min/max only
    logic        intRes;  // checked for compares only
    logic        nv;
  } vecT;

  logic        clk = 1'b0;
  logic        arstN;
  wbReqT       wbReq;
  wbRspT       wbRsp;
  vecT         vecs [NUM_BATCHES * NUM_LANES];
  int          numVec = 0;
  int          mismatches = 0;
  int          failures = 0;
  int          cycles = 0;
  logic [31:0] lcgState;

  fpCmpTop #(.NUM_LANES(NUM_LANES)) u_dut (
    .clk   (clk),
    .arstN (arstN),
    .wbReq (wbReq),
    .wbRsp (wbRsp)
  );

  always #5 clk = ~clk;

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      $display("timeout, the run did not finish within %0d cycles", MAX_CYCLES);
      $display("mismatches: %0d, other failures: %0d", mismatches, failures + 1);
      $display("STATUS: FAIL");
      $finish;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // stimulus helpers
  //////////////////////////////////////////////////////////////////////

  function automatic logic [31:0] lcgNext();
    lcgState = lcgState * 32'd1664525 + 32'd1013904223;
    return lcgState;
  endfunction

  // exponent 1..254, never zero/inf/NaN
  function automatic logic [31:0] randNormal();
    logic [31:0] a, b;
    logic [7:0]  e;
    a = lcgNext();
    b = lcgNext();
    e = 8'd1 + 8'(a[30:8] % 254);
    return {a[31], e, b[31:9]};
  endfunction

  // signed magnitude mapped onto a signed line
  function automatic logic signed [32:0] orderKey(input logic [31:0] w);
    logic signed [32:0] mag;
    mag = {2'b00, w[30:0]};
    return w[31] ? -mag : mag;
  endfunction

  task automatic addVec(input logic [31:0] x, y, input logic [2:0] op, input logic zfa,
                        input logic [31:0] fpRes, input logic intRes, nv);
    vecs[numVec].x      = x;
    vecs[numVec].y      = y;
    vecs[numVec].op     = op;
    vecs[numVec].zfa    = zfa;
    vecs[numVec].fpRes  = fpRes;
    vecs[numVec].intRes = intRes;
    vecs[numVec].nv     = nv;
    numVec++;
  endtask

  task automatic addRandomBatch();
    logic [31:0] r, x, y, mm;
    logic [2:0]  op;
    logic        lt, eq, intRes;
    r = lcgNext();
    case (r[31:16] % 5)
      0: op = CMP_LT;
      1: op = CMP_EQ;
      2: op = CMP_LE;
      3: op = CMP_MAX;
      default: op = CMP_MIN;
    endcase
    for (int l = 0; l < NUM_LANES; l++) begin
      x = randNormal();
      y = randNormal();
      if (y[3:0] == 4'd0)
        y = x;  // now and then an equal pair
      lt = orderKey(x) < orderKey(y);
      eq = (x == y);
      intRes = (op == CMP_EQ) ? eq : (op == CMP_LT) ? lt : (op == CMP_LE) ? (lt | eq) : 1'b0;
      if (op == CMP_MIN)
        mm = lt ? x : y;
      else
        mm = lt ? y : x;
      addVec(x, y, op, r[8], mm, intRes, 1'b0);
    end
  endtask

  // fixed edge cases, four per batch, then random batches
  task automatic buildTable();
    addVec(ONE,   TWO,   CMP_MIN, 1'b0, ONE,   1'b0, 1'b0);
    addVec(NZERO, PZERO, CMP_MIN, 1'b0, NZERO, 1'b0, 1'b0);  // -0 below +0
    addVec(ONE,   SNAN,  CMP_MIN, 1'b0, ONE,   1'b0, 1'b1);
    addVec(SNAN,  QNAN,  CMP_MIN, 1'b0, QNAN,  1'b0, 1'b1);
    addVec(MONE,  MTWO,  CMP_MAX, 1'b0, MONE,  1'b0, 1'b0);
    addVec(PZERO, NZERO, CMP_MAX, 1'b0, PZERO, 1'b0, 1'b0);
    addVec(QNAN,  ONE,   CMP_MAX, 1'b0, ONE,   1'b0, 1'b0);
    addVec(QNAN,  QNANP, CMP_MAX, 1'b0, QNAN,  1'b0, 1'b0);  // two NaNs, canonical
    addVec(ONE,   SNAN,  CMP_MAX, 1'b1, QNAN,  1'b0, 1'b1);  // maxm
    addVec(TWO,   MONE,  CMP_MAX, 1'b1, TWO,   1'b0, 1'b0);
    addVec(QNANP, ONE,   CMP_MAX, 1'b1, QNAN,  1'b0, 1'b0);
    addVec(NINF,  PINF,  CMP_MAX, 1'b1, PINF,  1'b0, 1'b0);
    addVec(PZERO, NZERO, CMP_EQ,  1'b0, PZERO, 1'b1, 1'b0);
    addVec(PINF,  PINF,  CMP_EQ,  1'b0, PZERO, 1'b1, 1'b0);
    addVec(QNAN,  QNAN,  CMP_EQ,  1'b0, PZERO, 1'b0, 1'b0);
    addVec(SNAN,  ONE,   CMP_EQ,  1'b0, PZERO, 1'b0, 1'b1);
    addVec(MTWO,  MONE,  CMP_LT,  1'b0, PZERO, 1'b1, 1'b0);
    addVec(NZERO, PZERO, CMP_LT,  1'b0, PZERO, 1'b0, 1'b0);
    addVec(QNAN,  ONE,   CMP_LT,  1'b0, PZERO, 1'b0, 1'b1);  // flt signals on quiet NaN
    addVec(NINF,  PINF,  CMP_LT,  1'b0, PZERO, 1'b1, 1'b0);
    addVec(SNAN,  ONE,   CMP_LE,  1'b1, PZERO, 1'b0, 1'b1);  // fleq
    addVec(QNAN,  TWO,   CMP_LE,  1'b1, PZERO, 1'b0, 1'b0);
    addVec(ONE,   ONE,   CMP_LE,  1'b1, PZERO, 1'b1, 1'b0);
    addVec(NZERO, PZERO, CMP_LE,  1'b1, PZERO, 1'b1, 1'b0);
    addVec(QNAN,  ONE,   CMP_MIN, 1'b1, QNAN,  1'b0, 1'b0);  // minm
    addVec(NINF,  ONE,   CMP_MIN, 1'b1, NINF,  1'b0, 1'b0);
    addVec(ONE,   SNAN,  CMP_MIN, 1'b1, QNAN,  1'b0, 1'b1);
    addVec(PZERO, NZERO, CMP_MIN, 1'b1, NZERO, 1'b0, 1'b0);
    for (int b = 0; b < 4; b++)
      addRandomBatch();
  endtask

  //////////////////////////////////////////////////////////////////////
  // bus access and checks
  //////////////////////////////////////////////////////////////////////

  // drive on the falling edge, hold until ack, then drop stb
  task automatic busAccess(input logic we, input logic [5:0] adr, input logic [31:0] wdat,
                           output logic [31:0] rdat);
    int waitCycles;
    waitCycles = 0;
    @(negedge clk);
    wbReq.cyc = 1'b1;
    wbReq.stb = 1'b1;
    wbReq.we  = we;
    wbReq.adr = adr;
    wbReq.dat = wdat;
    do begin
      @(negedge clk);
      waitCycles++;
    end while (!wbRsp.ack && waitCycles < 8);
    if (!wbRsp.ack) begin
      failures++;
      $display("no ack from the slave for the access at address %0d", adr);
    end
    rdat = wbRsp.dat;
    wbReq.cyc = 1'b0;
    wbReq.stb = 1'b0;
    wbReq.we  = 1'b0;
  endtask

  task automatic checkWord(input string what, input logic [31:0] got, exp);
    if (got !== exp) begin
      mismatches++;
      $display("** Error at time %0t: %s read %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic checkRegisters();
    logic [31:0] rd;
    busAccess(1'b0, STAT_ADR, '0, rd);
    checkWord("STAT before any start", rd, 32'h0);
    busAccess(1'b0, FPRES_BASE, '0, rd);
    checkWord("lane 0 fpRes after reset", rd, 32'h0);
    busAccess(1'b1, CTRL_ADR, 32'h0000_000B, rd);  // fleq, no start
    busAccess(1'b0, CTRL_ADR, '0, rd);
    checkWord("CTRL readback", rd, 32'h0000_000B);
    busAccess(1'b1, 6'd7, 32'h1234_5678, rd);
    busAccess(1'b0, 6'd7, '0, rd);
    checkWord("lane 3 Y readback", rd, 32'h1234_5678);
    busAccess(1'b1, 6'd20, 32'hFFFF_FFFF, rd);
    busAccess(1'b0, 6'd20, '0, rd);
    checkWord("unmapped address 20", rd, 32'h0);
    busAccess(1'b0, 6'd8, '0, rd);                 // lane 4 X, beyond NUM_LANES
    checkWord("unmapped lane 4 X", rd, 32'h0);
  endtask

  task automatic runBatch(input int base);
    logic [31:0] rd, expStat;
    int          tries;
    vecT         v;
    expStat = 32'h1;  // done
    for (int l = 0; l < NUM_LANES; l++) begin
      busAccess(1'b1, 6'(2 * l), vecs[base + l].x, rd);
      busAccess(1'b1, 6'(2 * l + 1), vecs[base + l].y, rd);
      expStat[STAT_NV_LSB + l] = vecs[base + l].nv;
    end
    busAccess(1'b1, CTRL_ADR, {23'b0, 1'b1, 4'b0, vecs[base].zfa, vecs[base].op}, rd);
    rd = '0;
    tries = 0;
    while (!rd[0] && tries < 10) begin
      busAccess(1'b0, STAT_ADR, '0, rd);
      tries++;
    end
    if (!rd[0]) begin
      failures++;
      $display("done never set for the batch starting at entry %0d", base);
    end else begin
      checkWord($sformatf("STAT of batch at entry %0d", base), rd, expStat);
    end
    for (int l = 0; l < NUM_LANES; l++) begin
      v = vecs[base + l];
      if (v.op[2]) begin  // min/max
        busAccess(1'b0, FPRES_BASE + 6'(l), '0, rd);
        checkWord($sformatf("lane %0d fpRes, x %h y %h op %b zfa %b", l, v.x, v.y, v.op,
                            v.zfa), rd, v.fpRes);
      end else begin
        busAccess(1'b0, INTRES_BASE + 6'(l), '0, rd);
        checkWord($sformatf("lane %0d intRes, x %h y %h op %b zfa %b", l, v.x, v.y, v.op,
                            v.zfa), rd, {31'b0, v.intRes});
      end
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // main sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    wbReq    = '0;
    arstN    = 1'b0;
    lcgState = SEED;
    buildTable();
    repeat (16) @(negedge clk);
    arstN = 1'b1;
    checkRegisters();
    for (int b = 0; b < numVec / NUM_LANES; b++)
      runBatch(b * NUM_LANES);
    $display("mismatches: %0d, other failures: %0d", mismatches, failures);
    if (mismatches == 0 && failures == 0)
      $display("STATUS: PASS");
    else
      $display("STATUS: FAIL");
    $finish;
  end

endmodule

/* fpCmpTb_chk.sv */
// bus protocol and start-to-done latency checks, bound into fpCmpTop
// assumes a single master that never back-to-backs its strobes

module fpCmpTb_chk
  import wbPkg::*;
(
  input logic  clk,
  input logic  arstN,
  input wbReqT wbReq,
  input wbRspT wbRsp,
  input logic  start,
  input logic  done
);

  // ack is a one-cycle pulse
  ackOnePulse: assert property (@(posedge clk) disable iff (!arstN)
    wbRsp.ack |=> !wbRsp.ack)
    else $error("ack stayed high for more than one cycle");

  ackNeedsReq: assert property (@(posedge clk) disable iff (!arstN)
    wbRsp.ack |-> $past(wbReq.cyc && wbReq.stb))
    else $error("ack without a preceding cyc and stb");

  // lanes at start+1, collector at start+2
  doneAfterStart: assert property (@(posedge clk) disable iff (!arstN)
    start |=> !done ##1 done)
    else $error("done did not rise two cycles after start");

  doneOnlyFromStart: assert property (@(posedge clk) disable iff (!arstN)
    $rose(done) |-> $past(start, 2))
    else $error("done rose without a start two cycles earlier");

  noStartInReset: assert property (@(posedge clk) !arstN |-> !start)
    else $error("start high during reset");

endmodule

bind fpCmpTop fpCmpTb_chk u_chk (
  .clk   (clk),
  .arstN (arstN),
  .wbReq (wbReq),
  .wbRsp (wbRsp),
  .start (start),
  .done  (status[0])
);

/* fpCmpTop.sv */
// compare accelerator top, NUM_LANES must stay within 1..8
// (operand map has room for eight x/y pairs)
// wiring only, all state lives in the submodules

module fpCmpTop
  import fpCmpPkg::*;
  import wbPkg::*;
#(
  parameter int NUM_LANES = 4,
  parameter bit IEEE_NAN  = 1'b0
) (
  input  logic  clk,
  input  logic  arstN,
  input  wbReqT wbReq,
  output wbRspT wbRsp
);

  lanePairT    pairs     [NUM_LANES];
  cmpCtrlT     ctrl;
  logic        start;
  laneResT     laneRes   [NUM_LANES];
  logic        laneValid [NUM_LANES];
  laneResT     results   [NUM_LANES];  // captured copy, read over the bus
  logic [31:0] status;

  cmpOperandRegs #(.NUM_LANES(NUM_LANES)) u_regs (
    .clk     (clk),
    .arstN   (arstN),
    .wbReq   (wbReq),
    .wbRsp   (wbRsp),
    .pairs   (pairs),
    .ctrl    (ctrl),
    .start   (start),
    .results (results),
    .status  (status)
  );

  // identical lanes, shared control and start
  for (genvar i = 0; i < NUM_LANES; i++) begin : gLane
    fpCmpLane #(.IEEE_NAN(IEEE_NAN)) u_lane (
      .clk   (clk),
      .arstN (arstN),
      .pair  (pairs[i]),
      .ctrl  (ctrl),
      .start (start),
      .res   (laneRes[i]),
      .valid (laneValid[i])
    );
  end

  cmpResultCollect #(.NUM_LANES(NUM_LANES)) u_collect (
    .clk       (clk),
    .arstN     (arstN),
    .laneRes   (laneRes),
    .laneValid (laneValid),
    .start     (start),
    .results   (results),
    .status    (status)
  );

endmodule

/* wbPkg.sv */
// wishbone classic, 32-bit data, 6-bit word address
// lane slots beyond NUM_LANES decode as unmapped

package wbPkg;

  typedef struct packed {
    logic        cyc;
    logic        stb;
    logic        we;
    logic [5:0]  adr;  // word address
    logic [31:0] dat;  // write data
  } wbReqT;

  typedef struct packed {
    logic        ack;
    logic [31:0] dat;  // read data, valid with ack
  } wbRspT;

  //////////////////////////////////////////////////////////////////////
  // register map, word addresses
  //////////////////////////////////////////////////////////////////////

  // operands live at 2i (x) and 2i+1 (y)
  parameter logic [5:0] CTRL_ADR    = 6'd16;
  parameter logic [5:0] STAT_ADR    = 6'd17;
  parameter logic [5:0] FPRES_BASE  = 6'd32;
  parameter logic [5:0] INTRES_BASE = 6'd48;

  parameter int CTRL_ZFA_BIT   = 3;  // op sits in 2..0
  parameter int CTRL_START_BIT = 8;  // write-only pulse
  parameter int STAT_DONE_BIT  = 0;
  parameter int STAT_NV_LSB    = 8;  // sticky nv of lane i at 8+i

endpackage
